// File: dv/mreq_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "mreq_config.svh"

module mreq_tb;

localparam int AW = `MREQ_ADDR_WIDTH;
localparam int IW = `MREQ_ID_WIDTH;
localparam int OFF_W = `MREQ_OFFSET_WIDTH;
localparam int IDX_W = `MREQ_INDEX_WIDTH;
localparam int TAG_W = AW - IDX_W - OFF_W;
localparam int ENTRIES = 1 << IDX_W;
localparam int CREDITS = `MREQ_CREDITS;

logic		clk = 1'b0;
logic		rst_n;
logic [IW-1:0]	arid, awid;
logic [AW-1:0]	araddr, awaddr;
logic		arvalid, awvalid, arready, awready;
logic		credit = 1'b0;
logic		rsp_valid, rsp_write, rsp_hit;
logic [IW-1:0]	rsp_id;
logic [AW-1:0]	rsp_addr;

int		errors = 0;
int		checks = 0;
int		err_base = 0;
int		test_num = 0;
bit		timed_out = 1'b0;
bit		credit_pause = 1'b0;
int		rsp_seen = 0;	// written only by the monitor
int		rsp_checked = 0;
int		credits_returned = 0;
logic [31:0]	rng = 32'h5eaf;

// reference directory
logic [ENTRIES-1:0]	ref_valid;
logic [TAG_W-1:0]	ref_tag [ENTRIES];

bit		exp_write[$], exp_hit[$], accept_order[$];
logic [IW-1:0]	exp_id[$];
logic [AW-1:0]	exp_addr[$];
bit		got_write[$], got_hit[$];
logic [IW-1:0]	got_id[$];
logic [AW-1:0]	got_addr[$];

mreq_top DUT (
	.clk		(clk),
	.rst_n		(rst_n),
	.arid_i		(arid),
	.araddr_i	(araddr),
	.arvalid_i	(arvalid),
	.arready_o	(arready),
	.awid_i		(awid),
	.awaddr_i	(awaddr),
	.awvalid_i	(awvalid),
	.awready_o	(awready),
	.credit_i	(credit),
	.rsp_valid_o	(rsp_valid),
	.rsp_write_o	(rsp_write),
	.rsp_hit_o	(rsp_hit),
	.rsp_id_o	(rsp_id),
	.rsp_addr_o	(rsp_addr)
);

always #20 clk = ~clk;

// collect responses mid-cycle, where rsp_* are stable
always @(negedge clk) begin
	if (rst_n && rsp_valid) begin
		got_write.push_back(rsp_write);
		got_hit.push_back(rsp_hit);
		got_id.push_back(rsp_id);
		got_addr.push_back(rsp_addr);
		rsp_seen++;
	end
end

// one credit back per response, held while paused
always @(posedge clk) begin
	#1;
	if (rst_n && !credit_pause && (rsp_seen - credits_returned) > 0) begin
		credit = 1'b1;
		credits_returned++;
	end else begin
		credit = 1'b0;
	end
end

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s ^ (s << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [AW-1:0] make_addr(input logic [TAG_W-1:0] tag,
		input logic [IDX_W-1:0] idx, input logic [OFF_W-1:0] off);
	return {tag, idx, off};
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
	end
endtask

task automatic apply_reset();
	rst_n = 1'b0;
	ref_valid = '0;
	repeat (4) @(posedge clk);
	#1 rst_n = 1'b1;
endtask

// request taken by the DUT, predict its lookup in acceptance order
task automatic accept(input bit wr, input logic [IW-1:0] id, input logic [AW-1:0] addr);
	logic [IDX_W-1:0]	idx;
	logic [TAG_W-1:0]	tag;
	bit			hit;
	idx = addr[OFF_W +: IDX_W];
	tag = addr[AW-1 -: TAG_W];
	hit = ref_valid[idx] && (ref_tag[idx] == tag);
	if (wr) begin
		ref_valid[idx] = 1'b1;
		ref_tag[idx] = tag;
	end
	exp_write.push_back(wr);
	exp_hit.push_back(hit);
	exp_id.push_back(id);
	exp_addr.push_back(addr);
	accept_order.push_back(wr);
endtask

task automatic check_responses();
	while (rsp_checked < rsp_seen) begin
		if (exp_write.size() == 0) begin
			errors++;
			$display("a response arrived with no request outstanding");
		end else begin
			check_value("rsp_write_o", 64'(got_write[rsp_checked]), 64'(exp_write.pop_front()));
			check_value("rsp_hit_o", 64'(got_hit[rsp_checked]), 64'(exp_hit.pop_front()));
			check_value("rsp_id_o", 64'(got_id[rsp_checked]), 64'(exp_id.pop_front()));
			check_value("rsp_addr_o", got_addr[rsp_checked], exp_addr.pop_front());
		end
		rsp_checked++;
	end
endtask

// called at posedge + 1, returns there once every requested channel was accepted
task automatic issue(input bit do_rd, input logic [IW-1:0] rid, input logic [AW-1:0] raddr,
		input bit do_wr, input logic [IW-1:0] wid, input logic [AW-1:0] waddr);
	bit	rd_pend;
	bit	wr_pend;
	int	cycles;
	rd_pend = do_rd;
	wr_pend = do_wr;
	cycles = 0;
	arid = rid;
	araddr = raddr;
	awid = wid;
	awaddr = waddr;
	arvalid = do_rd;
	awvalid = do_wr;
	while ((rd_pend || wr_pend) && !timed_out) begin
		@(negedge clk);
		if (arready) begin
			accept(1'b0, rid, raddr);
			rd_pend = 1'b0;
		end
		if (awready) begin
			accept(1'b1, wid, waddr);
			wr_pend = 1'b0;
		end
		check_responses();
		@(posedge clk);
		#1;
		arvalid = rd_pend;
		awvalid = wr_pend;
		cycles++;
		if (cycles > 200 && (rd_pend || wr_pend)) begin
			timed_out = 1'b1;
			$display("timeout: request id 0x%0h not accepted in 200 cycles", do_rd ? rid : wid);
		end
	end
	arvalid = 1'b0;
	awvalid = 1'b0;
endtask

task automatic wait_drain();
	int cycles;
	cycles = 0;
	while (!timed_out && (exp_write.size() != 0 || rsp_seen != credits_returned)) begin
		@(negedge clk);
		check_responses();
		cycles++;
		if (cycles > 500) begin
			timed_out = 1'b1;
			$display("timeout: %0d responses still missing after 500 cycles", exp_write.size());
		end
	end
	@(posedge clk);
	#1;
endtask

task automatic report_test(input string name);
	test_num++;
	$display("test %0d %s finished with %0d errors", test_num, name, errors - err_base);
	err_base = errors;
endtask

task automatic cold_directory();
	logic [AW-1:0] a;
	a = make_addr(TAG_W'(1), 4'h3, 6'h08);
	issue(1'b1, 16'h0011, a, 1'b0, '0, '0);	// miss
	issue(1'b0, '0, '0, 1'b1, 16'h0012, a);	// miss, allocates
	issue(1'b1, 16'h0013, a, 1'b0, '0, '0);	// hit
	wait_drain();
	report_test("cold directory");
endtask

task automatic replacement();
	logic [AW-1:0] a_old;
	logic [AW-1:0] a_new;
	a_old = make_addr(TAG_W'(1), 4'h3, 6'h10);
	a_new = make_addr(TAG_W'(2), 4'h3, 6'h20);
	issue(1'b0, '0, '0, 1'b1, 16'h0021, a_new);
	issue(1'b1, 16'h0022, a_old, 1'b0, '0, '0);
	issue(1'b1, 16'h0023, a_new, 1'b0, '0, '0);
	wait_drain();
	report_test("replacement");
endtask

task automatic arbitration();
	int base;
	int n_rd;
	int n_wr;
	int cycles;
	apply_reset();	// arbiter back to read first
	base = accept_order.size();
	n_rd = 0;
	n_wr = 0;
	cycles = 0;
	// both channels stay valid, a new request follows each accepted one
	while ((n_rd < 4 || n_wr < 4) && !timed_out) begin
		arid = IW'(16'h0030 + n_rd);
		araddr = make_addr(TAG_W'(5), IDX_W'(n_rd), '0);
		arvalid = (n_rd < 4);
		awid = IW'(16'h0040 + n_wr);
		awaddr = make_addr(TAG_W'(6), IDX_W'(n_wr), '0);
		awvalid = (n_wr < 4);
		@(negedge clk);
		if (arready) begin
			accept(1'b0, arid, araddr);
			n_rd++;
		end
		if (awready) begin
			accept(1'b1, awid, awaddr);
			n_wr++;
		end
		check_responses();
		@(posedge clk);
		#1;
		cycles++;
		if (cycles > 200 && (n_rd < 4 || n_wr < 4)) begin
			timed_out = 1'b1;
			$display("timeout: AR and AW requests not all accepted in 200 cycles");
		end
	end
	arvalid = 1'b0;
	awvalid = 1'b0;
	wait_drain();
	for (int i = 0; i < 8; i++)
		check_value("rsp_write_o", 64'(accept_order[base + i]), 64'(i % 2));
	report_test("arbitration");
endtask

task automatic credit_backpressure();
	int base;
	int accepted;
	int quiet;
	int cycles;
	int limit;
	base = rsp_seen;
	accepted = 8;
	quiet = 0;
	cycles = 0;
	limit = CREDITS + 2 + `MREQ_QUEUE_DEPTH;	// sent, buffered for issue, queued
	credit_pause = 1'b1;
	for (int i = 0; i < 8; i++)
		issue(i[0], IW'(16'h0050 + i), make_addr(TAG_W'(7), IDX_W'(i), 6'h04),
			!i[0], IW'(16'h0050 + i), make_addr(TAG_W'(7), IDX_W'(i), 6'h04));
	// keep a read valid until the front end has refused it for 40 cycles
	arid = IW'(16'h0050 + accepted);
	araddr = make_addr(TAG_W'(7), IDX_W'(accepted), 6'h04);
	arvalid = 1'b1;
	while (quiet < 40 && accepted <= limit && !timed_out) begin
		@(negedge clk);
		if (arready) begin
			accept(1'b0, arid, araddr);
			accepted++;
			quiet = 0;
		end else begin
			quiet++;
		end
		check_responses();
		@(posedge clk);
		#1;
		arid = IW'(16'h0050 + accepted);
		araddr = make_addr(TAG_W'(7), IDX_W'(accepted), 6'h04);
		cycles++;
		if (cycles > 200 && quiet < 40) begin
			timed_out = 1'b1;
			$display("timeout: read ready never stayed low with credit return paused");
		end
	end
	if (accepted > limit) begin
		errors++;
		$display("%0d requests accepted with credit return paused, only %0d fit",
			accepted, limit);
	end
	if (rsp_seen - base > CREDITS) begin
		errors++;
		$display("%0d responses sent with only %0d credits", rsp_seen - base, CREDITS);
	end
	credit_pause = 1'b0;
	issue(1'b1, arid, araddr, 1'b0, '0, '0);	// held read goes through once credits return
	wait_drain();
	check_value("response count", 64'(rsp_seen - base), 64'(accepted + 1));
	report_test("credit back-pressure");
endtask

task automatic random_stream();
	logic [AW-1:0] a;
	for (int i = 0; i < 200 && !timed_out; i++) begin
		rng = xorshift(rng);
		// few tags per index so hits and replacements both show up
		a = make_addr(TAG_W'(rng[5:4]) + TAG_W'(64'h1000), rng[3:0], rng[11:6]);
		if (rng[12])
			issue(1'b0, '0, '0, 1'b1, rng[31:16], a);
		else
			issue(1'b1, rng[31:16], a, 1'b0, '0, '0);
	end
	wait_drain();
	report_test("random stream");
endtask

initial begin
	rst_n = 1'b0;
	arid = '0;
	araddr = '0;
	arvalid = 1'b0;
	awid = '0;
	awaddr = '0;
	awvalid = 1'b0;
	apply_reset();
	if (!timed_out)
		cold_directory();
	if (!timed_out)
		replacement();
	if (!timed_out)
		arbitration();
	if (!timed_out)
		credit_backpressure();
	if (!timed_out)
		random_stream();
	$display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
	if (!timed_out && errors == 0 && exp_write.size() == 0)
		$display(">>> PASS");
	else
		$display(">>> FAIL");
	$finish;
end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mreq_tb -f verilog.f -o mreq_sim

./obj_dir/mreq_sim | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
	exit 0
else
	exit 1
fi

// File: source/credit_issue.sv
`default_nettype none
`timescale 1ns/1ps

`include "mreq_config.svh"

module credit_issue import mreq_pkg::*; (
	input	wire				clk,
	input	wire				rst_n,

	// from the directory
	input	wire				res_valid_i,
	input	wire				res_write_i,
	input	wire				res_hit_i,
	input	wire [`MREQ_ID_WIDTH-1:0]	res_id_i,
	input	wire mreq_addr_u		res_addr_i,
	output	logic				slot_free_o,

	// downstream link
	input	wire				credit_i,
	output	logic				rsp_valid_o,
	output	logic				rsp_write_o,
	output	logic				rsp_hit_o,
	output	logic [`MREQ_ID_WIDTH-1:0]	rsp_id_o,
	output	logic [`MREQ_ADDR_WIDTH-1:0]	rsp_addr_o
);

localparam int CREDITS = `MREQ_CREDITS;
localparam int CW = $clog2(CREDITS + 1);

logic [1:0]			cnt, cnt_n;	// entries held, 0..2
logic				wr_ptr, rd_ptr;
logic [CW-1:0]			cred;
logic				send;

logic				ent_write [2];
logic				ent_hit [2];
logic [`MREQ_ID_WIDTH-1:0]	ent_id [2];
mreq_addr_u			ent_addr [2];

assign send = (cnt != 2'd0) && (cred != '0);
assign cnt_n = cnt + {1'b0, res_valid_i} - {1'b0, send};

// a pop now turns into a result next cycle, so count what is already arriving
assign slot_free_o = (cnt_n <= 2'd1);

assign rsp_valid_o = send;
assign rsp_write_o = ent_write[rd_ptr];
assign rsp_hit_o = ent_hit[rd_ptr];
assign rsp_id_o = ent_id[rd_ptr];
assign rsp_addr_o = ent_addr[rd_ptr].raw;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		cnt <= 2'd0;
		wr_ptr <= 1'b0;
		rd_ptr <= 1'b0;
		cred <= CW'(CREDITS);
	end else begin
		cnt <= cnt_n;
		if (res_valid_i)
			wr_ptr <= !wr_ptr;
		if (send)
			rd_ptr <= !rd_ptr;
		cred <= cred + CW'(credit_i) - CW'(send);	// return and spend may coincide
	end
end

always_ff @(posedge clk) begin
	if (res_valid_i) begin
		ent_write[wr_ptr] <= res_write_i;
		ent_hit[wr_ptr] <= res_hit_i;
		ent_id[wr_ptr] <= res_id_i;
		ent_addr[wr_ptr] <= res_addr_i;
	end
end

a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
	cred <= CW'(CREDITS))
	else $error("credit count above reset value");

// the directory must have held back its pop when the buffer was full
a_buf_room: assert property (@(posedge clk) disable iff (!rst_n)
	res_valid_i |-> (cnt != 2'd2) || send)
	else $error("result arrived with no free slot");

endmodule

`default_nettype wire

// File: source/index_extractor.sv
`default_nettype none
`timescale 1ns/1ps

`include "mreq_config.svh"

module index_extractor import mreq_pkg::*; (
	input	wire				clk,
	input	wire				rst_n,

	// AR channel
	input	wire [`MREQ_ID_WIDTH-1:0]	arid_i,
	input	wire [`MREQ_ADDR_WIDTH-1:0]	araddr_i,
	input	wire				arvalid_i,
	output	logic				arready_o,

	// AW channel
	input	wire [`MREQ_ID_WIDTH-1:0]	awid_i,
	input	wire [`MREQ_ADDR_WIDTH-1:0]	awaddr_i,
	input	wire				awvalid_i,
	output	logic				awready_o,

	// toward the request queue
	input	wire				q_afull_i,
	output	logic				q_push_o,
	output	mreq_word_t			q_word_o
);

localparam logic [1:0]	S_IDLE = 2'd0,
			S_RCAP = 2'd1,
			S_WCAP = 2'd2;

logic [1:0]	state, state_n;
logic		prio, prio_n;	// set: AW wins the next tie
logic		grant_r, grant_w;

// arbitration, nothing granted while the queue is nearly full
assign grant_r = !q_afull_i && arvalid_i && (!awvalid_i || !prio);
assign grant_w = !q_afull_i && awvalid_i && (!arvalid_i || prio);

// ready only in the sampling cycle
assign arready_o = (state == S_RCAP);
assign awready_o = (state == S_WCAP);

always_comb begin
	state_n = state;
	prio_n = prio;
	case (state)
		S_IDLE: begin
			if (grant_r) begin
				state_n = S_RCAP;
				prio_n = 1'b1;
			end else if (grant_w) begin
				state_n = S_WCAP;
				prio_n = 1'b0;
			end
		end
		S_RCAP: state_n = S_IDLE;
		S_WCAP: state_n = S_IDLE;
		default: state_n = S_IDLE;
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= S_IDLE;
		prio <= 1'b0;	// read first after reset
		q_push_o <= 1'b0;
	end else begin
		state <= state_n;
		prio <= prio_n;
		q_push_o <= arready_o || awready_o;	// word lands in the queue next cycle
	end
end

always_ff @(posedge clk) begin
	if (arready_o) begin
		q_word_o.write <= 1'b0;
		q_word_o.id <= arid_i;
		q_word_o.addr.raw <= araddr_i;
	end else if (awready_o) begin
		q_word_o.write <= 1'b1;
		q_word_o.id <= awid_i;
		q_word_o.addr.raw <= awaddr_i;
	end
end

// the granted request is still presented when it is sampled
a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
	(!arready_o || arvalid_i) && (!awready_o || awvalid_i))
	else $error("ready raised after the requester dropped valid");

endmodule

`default_nettype wire

// File: source/mreq_config.svh
`ifndef MREQ_CONFIG_SVH
`define MREQ_CONFIG_SVH

// AXI request fields
`define MREQ_ADDR_WIDTH		64
`define MREQ_ID_WIDTH		16

// address split, index sits just above the line offset
`define MREQ_OFFSET_WIDTH	6
`define MREQ_INDEX_WIDTH	4	// 16 directory entries

`define MREQ_QUEUE_DEPTH	4
`define MREQ_CREDITS		4	// downstream credits after reset

`endif

// File: source/mreq_pkg.sv
`default_nettype none

`include "mreq_config.svh"

package mreq_pkg;

	localparam int TAG_WIDTH = `MREQ_ADDR_WIDTH - `MREQ_INDEX_WIDTH - `MREQ_OFFSET_WIDTH;

	typedef struct packed {
		logic [TAG_WIDTH-1:0]		tag;
		logic [`MREQ_INDEX_WIDTH-1:0]	index;
		logic [`MREQ_OFFSET_WIDTH-1:0]	offset;
	} mreq_addr_fields_t;

	// same 64 bits, seen either whole or split for the directory
	typedef union packed {
		logic [`MREQ_ADDR_WIDTH-1:0]	raw;
		mreq_addr_fields_t		f;
	} mreq_addr_u;

	// one accepted request, 1 + 16 + 64 bits
	typedef struct packed {
		logic				write;	// 1 for AW, 0 for AR
		logic [`MREQ_ID_WIDTH-1:0]	id;
		mreq_addr_u			addr;
	} mreq_word_t;

endpackage

`default_nettype wire

// File: source/mreq_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "mreq_config.svh"

module mreq_top import mreq_pkg::*; (
	input	wire				clk,
	input	wire				rst_n,

	input	wire [`MREQ_ID_WIDTH-1:0]	arid_i,
	input	wire [`MREQ_ADDR_WIDTH-1:0]	araddr_i,
	input	wire				arvalid_i,
	output	logic				arready_o,

	input	wire [`MREQ_ID_WIDTH-1:0]	awid_i,
	input	wire [`MREQ_ADDR_WIDTH-1:0]	awaddr_i,
	input	wire				awvalid_i,
	output	logic				awready_o,

	input	wire				credit_i,
	output	logic				rsp_valid_o,
	output	logic				rsp_write_o,
	output	logic				rsp_hit_o,
	output	logic [`MREQ_ID_WIDTH-1:0]	rsp_id_o,
	output	logic [`MREQ_ADDR_WIDTH-1:0]	rsp_addr_o
);

// extractor <-> queue
logic				q_push;
mreq_word_t			q_word;
logic				q_afull;

// queue <-> directory
logic				q_empty;
mreq_word_t			q_head;
logic				q_pop;

// directory <-> issue
logic				res_valid;
logic				res_write;
logic				res_hit;
logic [`MREQ_ID_WIDTH-1:0]	res_id;
mreq_addr_u			res_addr;
logic				slot_free;

index_extractor u_extractor (
	.clk		(clk),
	.rst_n		(rst_n),
	.arid_i		(arid_i),
	.araddr_i	(araddr_i),
	.arvalid_i	(arvalid_i),
	.arready_o	(arready_o),
	.awid_i		(awid_i),
	.awaddr_i	(awaddr_i),
	.awvalid_i	(awvalid_i),
	.awready_o	(awready_o),
	.q_afull_i	(q_afull),
	.q_push_o	(q_push),
	.q_word_o	(q_word)
);

request_queue u_queue (
	.clk		(clk),
	.rst_n		(rst_n),
	.push_i		(q_push),
	.word_i		(q_word),
	.pop_i		(q_pop),
	.head_o		(q_head),
	.empty_o	(q_empty),
	.afull_o	(q_afull)
);

tag_directory u_directory (
	.clk		(clk),
	.rst_n		(rst_n),
	.head_i		(q_head),
	.empty_i	(q_empty),
	.slot_free_i	(slot_free),
	.pop_o		(q_pop),
	.res_valid_o	(res_valid),
	.res_write_o	(res_write),
	.res_hit_o	(res_hit),
	.res_id_o	(res_id),
	.res_addr_o	(res_addr)
);

credit_issue u_issue (
	.clk		(clk),
	.rst_n		(rst_n),
	.res_valid_i	(res_valid),
	.res_write_i	(res_write),
	.res_hit_i	(res_hit),
	.res_id_i	(res_id),
	.res_addr_i	(res_addr),
	.slot_free_o	(slot_free),
	.credit_i	(credit_i),
	.rsp_valid_o	(rsp_valid_o),
	.rsp_write_o	(rsp_write_o),
	.rsp_hit_o	(rsp_hit_o),
	.rsp_id_o	(rsp_id_o),
	.rsp_addr_o	(rsp_addr_o)
);

endmodule

`default_nettype wire

// File: source/request_queue.sv
`default_nettype none
`timescale 1ns/1ps

`include "mreq_config.svh"

module request_queue import mreq_pkg::*; (
	input	wire		clk,
	input	wire		rst_n,
	input	wire		push_i,
	input	wire mreq_word_t	word_i,
	input	wire		pop_i,
	output	mreq_word_t	head_o,
	output	logic		empty_o,
	output	logic		afull_o
);

localparam int DEPTH = `MREQ_QUEUE_DEPTH;
localparam int PW = $clog2(DEPTH);
localparam int CW = $clog2(DEPTH + 1);

mreq_word_t	mem [DEPTH];
logic [PW-1:0]	wr_ptr, rd_ptr;
logic [CW-1:0]	count;

assign head_o = mem[rd_ptr];	// head read in the pop cycle
assign empty_o = (count == '0);
// one slot kept back for the word the extractor may still be carrying
assign afull_o = (count >= CW'(DEPTH - 1));

always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (push_i)
			wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
		if (pop_i)
			rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		case ({push_i, pop_i})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (push_i)
		mem[wr_ptr] <= word_i;
end

a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
	push_i |-> (count != CW'(DEPTH)))
	else $error("push into a full request queue");

a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
	pop_i |-> !empty_o)
	else $error("pop from an empty request queue");

endmodule

`default_nettype wire

// File: source/tag_directory.sv
`default_nettype none
`timescale 1ns/1ps

`include "mreq_config.svh"

module tag_directory import mreq_pkg::*; (
	input	wire				clk,
	input	wire				rst_n,

	// queue head
	input	wire mreq_word_t		head_i,
	input	wire				empty_i,
	input	wire				slot_free_i,
	output	logic				pop_o,

	// lookup result
	output	logic				res_valid_o,
	output	logic				res_write_o,
	output	logic				res_hit_o,
	output	logic [`MREQ_ID_WIDTH-1:0]	res_id_o,
	output	mreq_addr_u			res_addr_o
);

localparam int ENTRIES = 1 << `MREQ_INDEX_WIDTH;

logic [ENTRIES-1:0]		valid_q;
logic [TAG_WIDTH-1:0]		tag_q [ENTRIES];
logic [`MREQ_INDEX_WIDTH-1:0]	idx;
logic				hit;

// take the head only when issue can still absorb the result
assign pop_o = !empty_i && slot_free_i;

assign idx = head_i.addr.f.index;
assign hit = valid_q[idx] && (tag_q[idx] == head_i.addr.f.tag);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		valid_q <= '0;
		res_valid_o <= 1'b0;
	end else begin
		res_valid_o <= pop_o;
		if (pop_o && head_i.write)
			valid_q[idx] <= 1'b1;	// write allocates
	end
end

// hit is sampled before the allocate takes effect
always_ff @(posedge clk) begin
	if (pop_o) begin
		res_write_o <= head_i.write;
		res_hit_o <= hit;
		res_id_o <= head_i.id;
		res_addr_o <= head_i.addr;
		if (head_i.write)
			tag_q[idx] <= head_i.addr.f.tag;
	end
end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/mreq_pkg.sv
source/index_extractor.sv
source/request_queue.sv
source/tag_directory.sv
source/credit_issue.sv
source/mreq_top.sv
dv/mreq_tb.sv
